// File: sources.f
+incdir+logic
logic/error_record_pkg.sv
logic/error_csr_pkg.sv
logic/error_source_merge.sv
logic/error_log_sequencer.sv
logic/error_log_regs.sv
logic/error_csr_wb.sv
logic/error_log_top.sv
testbench/error_log_assert.sv
testbench/error_log_tb.sv

// File: Bender.yml
package:
  name: error_log

sources:
  - include_dirs:
      - logic
    files:
      - logic/error_record_pkg.sv
      - logic/error_csr_pkg.sv
      - logic/error_source_merge.sv
      - logic/error_log_sequencer.sv
      - logic/error_log_regs.sv
      - logic/error_csr_wb.sv
      - logic/error_log_top.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - testbench/error_log_assert.sv
      - testbench/error_log_tb.sv

// File: testbench/error_log_tb.sv
// Table-driven testbench for the error logger with Wishbone read and acknowledge tasks
`timescale 1ns/1ps
`include "error_log_params.svh"

module error_log_tb;

  localparam int KIND_NONE     = 0;
  localparam int KIND_1A       = 1;
  localparam int KIND_1B       = 2;
  localparam int KIND_OTHER    = 3;
  localparam int PULSE_TIMEOUT = 20;
  localparam int ACK_TIMEOUT   = 8;

  typedef struct {
    string name;
    bit    err_1a;
    bit    err_1b;
    bit    slverr_wr;
    bit    slverr_rd;
    bit    poison_rd;
    bit    busy;
    bit    self_check_en;
    int    kind;
    bit    set_to_busy;
  } test_row_t;

  logic                  clk;
  logic                  reset_n;
  logic                  i_busy;
  logic                  i_set_to_busy;
  logic                  i_self_check_en;
  logic                  i_force_disable;
  logic                  i_err_1a;
  logic [`PATTERN_W-1:0] i_observed_1a;
  logic [`PATTERN_W-1:0] i_expected_1a;
  logic [`LOOP_W-1:0]    i_loop_1a;
  logic [`OFFSET_W-1:0]  i_offset_1a;
  logic [`SET_W-1:0]     i_set_1a;
  logic [`INCR_W-1:0]    i_incr_1a;
  logic [`ADDR_W-1:0]    i_addr_1a;
  logic                  i_err_1b;
  logic [`PATTERN_W-1:0] i_observed_1b;
  logic [`PATTERN_W-1:0] i_expected_1b;
  logic [`LOOP_W-1:0]    i_loop_1b;
  logic [`OFFSET_W-1:0]  i_offset_1b;
  logic [`SET_W-1:0]     i_set_1b;
  logic [`INCR_W-1:0]    i_incr_1b;
  logic [`ADDR_W-1:0]    i_addr_1b;
  logic                  i_slverr_wr;
  logic                  i_slverr_rd;
  logic                  i_poison_rd;
  logic                  o_record_error;
  logic                  i_wb_cyc;
  logic                  i_wb_stb;
  logic                  i_wb_we;
  logic [`WB_ADR_W-1:0]  i_wb_adr;
  logic [`WB_DAT_W-1:0]  i_wb_dat;
  logic [`WB_DAT_W-1:0]  o_wb_dat;
  logic                  o_wb_ack;

  test_row_t             rows[$];
  logic [`WB_DAT_W-1:0]  exp_word[0:5];
  string                 word_name[0:5];
  logic [`WB_DAT_W-1:0]  rd_data;
  integer                seed;
  int                    error_count;
  int                    tests_run;
  int                    tests_failed;
  bit                    ack_ok;
  bit                    pulse_seen;

  error_log_top UUT (.*);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic add_row(input string name, input bit e1a, input bit e1b, input bit wr,
                         input bit rd, input bit poison, input bit busy, input bit en,
                         input int kind, input bit clr);
    test_row_t row;
    row = '{name, e1a, e1b, wr, rd, poison, busy, en, kind, clr};
    rows.push_back(row);
  endtask

  task automatic randomize_records();
    i_observed_1a = $random(seed);
    i_expected_1a = $random(seed);
    i_loop_1a     = $random(seed);
    i_offset_1a   = $random(seed);
    i_set_1a      = $random(seed);
    i_incr_1a     = $random(seed);
    i_addr_1a     = {$random(seed), $random(seed)};
    i_observed_1b = $random(seed);
    i_expected_1b = $random(seed);
    i_loop_1b     = $random(seed);
    i_offset_1b   = $random(seed);
    i_set_1b      = $random(seed);
    i_incr_1b     = $random(seed);
    i_addr_1b     = {$random(seed), $random(seed)};
  endtask

  // One Wishbone classic access, started just after a rising edge
  task automatic wb_access(input bit we, input logic [`WB_ADR_W-1:0] adr,
                           input logic [`WB_DAT_W-1:0] wdat,
                           output logic [`WB_DAT_W-1:0] rdat, output bit ok);
    int waited;
    ok       = 1'b0;
    rdat     = '0;
    waited   = 0;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    while (!ok && waited < ACK_TIMEOUT)
    begin
      next_cycle();
      waited++;
      if (o_wb_ack)
      begin
        ok   = 1'b1;
        rdat = o_wb_dat;
      end
    end
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
  endtask

  task automatic expect_record(input logic [`PATTERN_W-1:0] obs,
                               input logic [`PATTERN_W-1:0] expd,
                               input logic [`LOOP_W-1:0] loop_num,
                               input logic [`OFFSET_W-1:0] offset,
                               input logic [`SET_W-1:0] set_num,
                               input logic [`INCR_W-1:0] incr,
                               input logic [`ADDR_W-1:0] addr, input logic status);
    exp_word[0] = obs;
    exp_word[1] = expd;
    // Status word holds the error bit, loop number in 15:8 and byte offset in 23:16
    exp_word[2] = {8'h00, offset, loop_num, 7'h00, status};
    exp_word[3] = {16'h0000, incr, 4'h0, set_num};
    exp_word[4] = addr[31:0];
    exp_word[5] = addr[63:32];
  endtask

  task automatic set_expected(input int kind);
    case (kind)
      KIND_1A:
        expect_record(i_observed_1a, i_expected_1a, i_loop_1a, i_offset_1a, i_set_1a,
                      i_incr_1a, i_addr_1a, 1'b1);
      KIND_1B:
        expect_record(i_observed_1b, i_expected_1b, i_loop_1b, i_offset_1b, i_set_1b,
                      i_incr_1b, i_addr_1b, 1'b1);
      // With 1a silent the merged record is the 1b one, and only its loop number is kept
      KIND_OTHER:
        expect_record('0, '0, i_loop_1b, '0, '0, '0, '0, 1'b1);
      default:
        expect_record('0, '0, '0, '0, '0, '0, '0, 1'b0);
    endcase
  endtask

  task automatic check_all_words(input string when_txt, inout bit test_bad);
    logic [`WB_DAT_W-1:0] data;
    bit                   ok;
    int                   w;
    for (w = 0; w < 6; w++)
    begin
      wb_access(1'b0, 3'(w), '0, data, ok);
      if (!ok)
      begin
        $display("Wishbone read of word %0d got no ack %s", w, when_txt);
        error_count++;
        test_bad = 1'b1;
      end
      else if (data !== exp_word[w])
      begin
        $display("CHECK FAILED: %s %s got %h expected %h", word_name[w], when_txt,
                 data, exp_word[w]);
        error_count++;
        test_bad = 1'b1;
      end
    end
  endtask

  initial
  begin
    test_row_t row;
    bit        test_bad;
    int        waited;
    seed            = 32'hea2137eb;
    error_count     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    reset_n         = 1'b0;
    i_busy          = 1'b0;
    i_set_to_busy   = 1'b0;
    i_self_check_en = 1'b0;
    i_force_disable = 1'b0;
    i_err_1a        = 1'b0;
    i_err_1b        = 1'b0;
    i_slverr_wr     = 1'b0;
    i_slverr_rd     = 1'b0;
    i_poison_rd     = 1'b0;
    i_wb_cyc        = 1'b0;
    i_wb_stb        = 1'b0;
    i_wb_we         = 1'b0;
    i_wb_adr        = '0;
    i_wb_dat        = '0;
    randomize_records();
    word_name = '{"o_wb_dat word 0 observed", "o_wb_dat word 1 expected",
                  "o_wb_dat word 2 status", "o_wb_dat word 3 set/incr",
                  "o_wb_dat word 4 addr lo", "o_wb_dat word 5 addr hi"};

    //       name              1a 1b wr rd ps busy en kind        set_to_busy
    add_row("1a alone",         1, 0, 0, 0, 0, 1,   1, KIND_1A,    0);
    add_row("1a and 1b",        1, 1, 0, 0, 0, 1,   1, KIND_1A,    0);
    add_row("1b alone",         0, 1, 0, 0, 0, 1,   1, KIND_1B,    0);
    add_row("read poison",      0, 0, 0, 0, 1, 1,   1, KIND_OTHER, 0);
    add_row("write slverr",     0, 0, 1, 0, 0, 1,   1, KIND_OTHER, 0);
    add_row("read slverr",      0, 0, 0, 1, 0, 1,   1, KIND_OTHER, 0);
    add_row("1a while idle",    1, 0, 0, 0, 0, 0,   1, KIND_NONE,  0);
    add_row("poison while idle", 0, 0, 0, 0, 1, 0,  1, KIND_NONE,  0);
    add_row("1a check off",     1, 0, 0, 0, 0, 1,   0, KIND_NONE,  0);
    add_row("1b then new run",  0, 1, 0, 0, 0, 1,   1, KIND_1B,    1);
    add_row("1a after new run", 1, 0, 0, 0, 0, 1,   1, KIND_1A,    0);

    repeat (5) @(posedge clk);
    #10;
    reset_n = 1'b1;

    test_bad = 1'b0;
    tests_run++;
    if (o_record_error !== 1'b0)
    begin
      $display("CHECK FAILED: o_record_error after reset got %h expected 0", o_record_error);
      error_count++;
      test_bad = 1'b1;
    end
    if (o_wb_ack !== 1'b0)
    begin
      $display("CHECK FAILED: o_wb_ack after reset got %h expected 0", o_wb_ack);
      error_count++;
      test_bad = 1'b1;
    end
    set_expected(KIND_NONE);
    check_all_words("after reset", test_bad);
    tests_failed += test_bad;
    $display("Test reset state: %s", test_bad ? "FAILED" : "ok");

    foreach (rows[t])
    begin
      row      = rows[t];
      test_bad = 1'b0;
      tests_run++;
      randomize_records();
      i_busy          = row.busy;
      i_self_check_en = row.self_check_en;
      i_err_1a        = row.err_1a;
      i_err_1b        = row.err_1b;
      i_slverr_wr     = row.slverr_wr;
      i_slverr_rd     = row.slverr_rd;
      i_poison_rd     = row.poison_rd;
      next_cycle();
      i_err_1a        = 1'b0;
      i_err_1b        = 1'b0;
      i_slverr_wr     = 1'b0;
      i_slverr_rd     = 1'b0;
      i_poison_rd     = 1'b0;
      i_busy          = 1'b1;
      i_self_check_en = 1'b1;

      pulse_seen = 1'b0;
      waited     = 0;
      while (!pulse_seen && waited < PULSE_TIMEOUT)
      begin
        next_cycle();
        waited++;
        pulse_seen = o_record_error;
      end

      if (row.kind == KIND_NONE)
      begin
        if (pulse_seen)
        begin
          $display("Record pulse raised for an error that should have been ignored");
          error_count++;
          test_bad = 1'b1;
        end
        set_expected(KIND_NONE);
        check_all_words("with nothing recorded", test_bad);
      end
      else if (!pulse_seen)
      begin
        $display("No record pulse within %0d cycles of the error", PULSE_TIMEOUT);
        error_count++;
        test_bad = 1'b1;
      end
      else
      begin
        set_expected(row.kind);
        check_all_words("while held", test_bad);
        if (row.set_to_busy)
        begin
          i_set_to_busy = 1'b1;
          next_cycle();
          i_set_to_busy = 1'b0;
        end
        else
        begin
          wb_access(1'b1, 3'd2, 32'h0, rd_data, ack_ok);
          if (!ack_ok)
          begin
            $display("Wishbone acknowledge write got no ack");
            error_count++;
            test_bad = 1'b1;
          end
        end
        repeat (3) next_cycle();
        set_expected(KIND_NONE);
        check_all_words("after release", test_bad);
      end
      tests_failed += test_bad;
      $display("Test %0d %s: %s", t, row.name, test_bad ? "FAILED" : "ok");
    end

    $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
             error_count);
    if (tests_failed == 0 && error_count == 0)
    begin
      $display("TB PASSED");
    end
    else
    begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/error_log_assert.sv
// Concurrent checks on the record pulse and the Wishbone handshake, with their bind statements
`timescale 1ns/1ps

module error_log_assert (
  input logic clk,
  input logic reset_n,
  input logic i_record_error,
  input logic i_wb_cyc,
  input logic i_wb_stb,
  input logic i_wb_ack
);

  // The record pulse lasts exactly one cycle
  pulse_single_cycle: assert property (@(posedge clk) disable iff (!reset_n)
    i_record_error |=> !i_record_error)
    else $error("record pulse stayed high for two cycles");

  // A request that has no ack yet gets one on the next edge
  ack_follows_stb: assert property (@(posedge clk) disable iff (!reset_n)
    (i_wb_cyc && i_wb_stb && !i_wb_ack) |=> i_wb_ack)
    else $error("no Wishbone ack one cycle after stb");

  ack_needs_stb: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(i_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
    else $error("Wishbone ack raised without a request");

endmodule

// The sequencer has no bus, so only the pulse check is live there
bind error_log_sequencer error_log_assert u_seq_assert (
  .clk            (clk),
  .reset_n        (reset_n),
  .i_record_error (o_record_error),
  .i_wb_cyc       (1'b0),
  .i_wb_stb       (1'b0),
  .i_wb_ack       (1'b0)
);

bind error_csr_wb error_log_assert u_wb_assert (
  .clk            (clk),
  .reset_n        (reset_n),
  .i_record_error (1'b0),
  .i_wb_cyc       (i_wb_cyc),
  .i_wb_stb       (i_wb_stb),
  .i_wb_ack       (o_wb_ack)
);

// File: logic/error_log_top.sv
// Error logger top level joining source merge, sequencer, log registers and Wishbone port
`timescale 1ns/1ps
`include "error_log_params.svh"

module error_log_top (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  i_busy,
  input  logic                  i_set_to_busy,
  input  logic                  i_self_check_en,
  input  logic                  i_force_disable,
  input  logic                  i_err_1a,
  input  logic [`PATTERN_W-1:0] i_observed_1a,
  input  logic [`PATTERN_W-1:0] i_expected_1a,
  input  logic [`LOOP_W-1:0]    i_loop_1a,
  input  logic [`OFFSET_W-1:0]  i_offset_1a,
  input  logic [`SET_W-1:0]     i_set_1a,
  input  logic [`INCR_W-1:0]    i_incr_1a,
  input  logic [`ADDR_W-1:0]    i_addr_1a,
  input  logic                  i_err_1b,
  input  logic [`PATTERN_W-1:0] i_observed_1b,
  input  logic [`PATTERN_W-1:0] i_expected_1b,
  input  logic [`LOOP_W-1:0]    i_loop_1b,
  input  logic [`OFFSET_W-1:0]  i_offset_1b,
  input  logic [`SET_W-1:0]     i_set_1b,
  input  logic [`INCR_W-1:0]    i_incr_1b,
  input  logic [`ADDR_W-1:0]    i_addr_1b,
  input  logic                  i_slverr_wr,
  input  logic                  i_slverr_rd,
  input  logic                  i_poison_rd,
  output logic                  o_record_error,
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  logic [`WB_ADR_W-1:0]  i_wb_adr,
  input  logic [`WB_DAT_W-1:0]  i_wb_dat,
  output logic [`WB_DAT_W-1:0]  o_wb_dat,
  output logic                  o_wb_ack
);

  error_record_pkg::error_record_t rec_1a;
  error_record_pkg::error_record_t rec_1b;
  error_record_pkg::error_record_t rec;
  logic                  self_err;
  logic                  resp_err;
  logic                  record;
  logic                  record_other;
  logic                  clear;
  logic                  status_clear;
  logic                  error_status;
  logic [`PATTERN_W-1:0] observed;
  logic [`PATTERN_W-1:0] expected;
  logic [`LOOP_W-1:0]    loop_num;
  logic [`OFFSET_W-1:0]  offset;
  logic [`SET_W-1:0]     set_num;
  logic [`INCR_W-1:0]    incr;
  logic [`ADDR_W-1:0]    addr;

  assign rec_1a = '{observed: i_observed_1a, expected: i_expected_1a, loop_num: i_loop_1a,
                    offset: i_offset_1a, set_num: i_set_1a, incr: i_incr_1a,
                    addr: i_addr_1a};
  assign rec_1b = '{observed: i_observed_1b, expected: i_expected_1b, loop_num: i_loop_1b,
                    offset: i_offset_1b, set_num: i_set_1b, incr: i_incr_1b,
                    addr: i_addr_1b};

  error_source_merge u_merge (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_busy          (i_busy),
    .i_self_check_en (i_self_check_en),
    .i_err_1a        (i_err_1a),
    .i_err_1b        (i_err_1b),
    .i_rec_1a        (rec_1a),
    .i_rec_1b        (rec_1b),
    .i_slverr_wr     (i_slverr_wr),
    .i_slverr_rd     (i_slverr_rd),
    .i_poison_rd     (i_poison_rd),
    .o_self_err      (self_err),
    .o_resp_err      (resp_err),
    .o_rec           (rec)
  );

  error_log_sequencer u_seq (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_force_disable (i_force_disable),
    .i_self_err      (self_err),
    .i_resp_err      (resp_err),
    .i_error_status  (error_status),
    .o_record        (record),
    .o_record_other  (record_other),
    .o_clear         (clear),
    .o_record_error  (o_record_error)
  );

  error_log_regs u_regs (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_set_to_busy  (i_set_to_busy),
    .i_record       (record),
    .i_record_other (record_other),
    .i_clear        (clear),
    .i_status_clear (status_clear),
    .i_rec          (rec),
    .o_error_status (error_status),
    .o_observed     (observed),
    .o_expected     (expected),
    .o_loop         (loop_num),
    .o_offset       (offset),
    .o_set          (set_num),
    .o_incr         (incr),
    .o_addr         (addr)
  );

  error_csr_wb u_csr (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .i_error_status (error_status),
    .i_observed     (observed),
    .i_expected     (expected),
    .i_loop         (loop_num),
    .i_offset       (offset),
    .i_set          (set_num),
    .i_incr         (incr),
    .i_addr         (addr),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .o_status_clear (status_clear)
  );

endmodule

// File: logic/error_csr_wb.sv
// Wishbone classic slave for reading the error logs and acknowledging status
`timescale 1ns/1ps
`include "error_log_params.svh"

module error_csr_wb (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic                  i_wb_cyc,
  input  logic                  i_wb_stb,
  input  logic                  i_wb_we,
  input  logic [`WB_ADR_W-1:0]  i_wb_adr,
  input  logic [`WB_DAT_W-1:0]  i_wb_dat,
  input  logic                  i_error_status,
  input  logic [`PATTERN_W-1:0] i_observed,
  input  logic [`PATTERN_W-1:0] i_expected,
  input  logic [`LOOP_W-1:0]    i_loop,
  input  logic [`OFFSET_W-1:0]  i_offset,
  input  logic [`SET_W-1:0]     i_set,
  input  logic [`INCR_W-1:0]    i_incr,
  input  logic [`ADDR_W-1:0]    i_addr,
  output logic [`WB_DAT_W-1:0]  o_wb_dat,
  output logic                  o_wb_ack,
  output logic                  o_status_clear
);

  error_csr_pkg::csr_word_t   word;
  error_csr_pkg::log_status_t status_word;
  error_csr_pkg::log_set_t    set_word;
  logic                       request;
  logic [`WB_DAT_W-1:0]       rd_data;

  assign word = error_csr_pkg::csr_word_t'(i_wb_adr);

  // New request only while no ack is out, giving one ack per access
  assign request = i_wb_cyc & i_wb_stb & ~o_wb_ack;

  // Writing status bit low is the software acknowledge
  assign o_status_clear = request & i_wb_we & (word == error_csr_pkg::CSR_STATUS)
                          & ~i_wb_dat[`STATUS_BIT];

  always_comb
  begin
    status_word              = '0;
    status_word.error_status = i_error_status;
    status_word.loop_num     = i_loop;
    status_word.offset       = i_offset;
    set_word                 = '0;
    set_word.set_num         = i_set;
    set_word.incr            = i_incr;
    case (word)
      error_csr_pkg::CSR_OBSERVED: rd_data = i_observed;
      error_csr_pkg::CSR_EXPECTED: rd_data = i_expected;
      error_csr_pkg::CSR_STATUS:   rd_data = status_word;
      error_csr_pkg::CSR_SET:      rd_data = set_word;
      error_csr_pkg::CSR_ADDR_LO:  rd_data = i_addr[`WB_DAT_W-1:0];
      error_csr_pkg::CSR_ADDR_HI:  rd_data = i_addr[`ADDR_W-1:`WB_DAT_W];
      default:                     rd_data = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_wb_ack <= 1'b0;
    end
    else
    begin
      o_wb_ack <= request;
    end
  end

  // Read data is captured with the ack so it is valid in the ack cycle
  always_ff @(posedge clk)
  begin
    if (request)
    begin
      o_wb_dat <= rd_data;
    end
  end

endmodule

// File: logic/error_log_regs.sv
// Debug log register bank with record, record-other, clear and status acknowledge
`timescale 1ns/1ps
`include "error_log_params.svh"

module error_log_regs (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_set_to_busy,
  input  logic                          i_record,
  input  logic                          i_record_other,
  input  logic                          i_clear,
  input  logic                          i_status_clear,
  input  error_record_pkg::error_record_t i_rec,
  output logic                          o_error_status,
  output logic [`PATTERN_W-1:0]         o_observed,
  output logic [`PATTERN_W-1:0]         o_expected,
  output logic [`LOOP_W-1:0]            o_loop,
  output logic [`OFFSET_W-1:0]          o_offset,
  output logic [`SET_W-1:0]             o_set,
  output logic [`INCR_W-1:0]            o_incr,
  output logic [`ADDR_W-1:0]            o_addr
);

  logic clear_all;

  // A new run and the end of an acknowledged error both wipe the logs
  assign clear_all = i_set_to_busy | i_clear;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_error_status <= 1'b0;
    end
    else if (clear_all)
    begin
      o_error_status <= 1'b0;
    end
    else if (i_record | i_record_other)
    begin
      o_error_status <= 1'b1;
    end
    else if (i_status_clear)
    begin
      o_error_status <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n || clear_all)
    begin
      o_observed <= '0;
      o_expected <= '0;
      o_loop     <= '0;
      o_offset   <= '0;
      o_set      <= '0;
      o_incr     <= '0;
      o_addr     <= '0;
    end
    else if (i_record)
    begin
      o_observed <= i_rec.observed;
      o_expected <= i_rec.expected;
      o_loop     <= i_rec.loop_num;
      o_offset   <= i_rec.offset;
      o_set      <= i_rec.set_num;
      o_incr     <= i_rec.incr;
      o_addr     <= i_rec.addr;
    end
    else if (i_record_other)
    begin
      // Response errors carry no pattern, so only the loop number is taken
      o_loop   <= i_rec.loop_num;
      o_offset <= '0;
    end
  end

endmodule

// File: logic/error_log_sequencer.sv
// Capture, announce, wait-for-acknowledge and clear FSM of the error logger
`timescale 1ns/1ps

module error_log_sequencer (
  input  logic clk,
  input  logic reset_n,
  input  logic i_force_disable,
  input  logic i_self_err,
  input  logic i_resp_err,
  input  logic i_error_status,
  output logic o_record,
  output logic o_record_other,
  output logic o_clear,
  output logic o_record_error
);

  error_record_pkg::seq_state_t state;
  error_record_pkg::seq_state_t next_state;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state <= error_record_pkg::SEQ_IDLE;
    end
    else if (i_force_disable)
    begin
      state <= error_record_pkg::SEQ_IDLE;
    end
    else
    begin
      state <= next_state;
    end
  end

  always_comb
  begin
    next_state     = state;
    o_record       = 1'b0;
    o_record_other = 1'b0;
    o_clear        = 1'b0;
    o_record_error = 1'b0;
    case (state)
      error_record_pkg::SEQ_IDLE:
      begin
        // Only an idle sequencer takes a new error
        if (i_self_err)
        begin
          next_state = error_record_pkg::SEQ_RECORD;
        end
        else if (i_resp_err)
        begin
          next_state = error_record_pkg::SEQ_OTHER;
        end
      end
      error_record_pkg::SEQ_RECORD:
      begin
        o_record   = 1'b1;
        next_state = error_record_pkg::SEQ_SEND;
      end
      error_record_pkg::SEQ_OTHER:
      begin
        o_record_other = 1'b1;
        next_state     = error_record_pkg::SEQ_SEND;
      end
      error_record_pkg::SEQ_SEND:
      begin
        // Logs loaded on the previous edge, so they are valid with the pulse
        o_record_error = 1'b1;
        next_state     = error_record_pkg::SEQ_WAIT_ACK;
      end
      error_record_pkg::SEQ_WAIT_ACK:
      begin
        // Software drops the status bit to release the logs
        if (!i_error_status)
        begin
          o_clear    = 1'b1;
          next_state = error_record_pkg::SEQ_COMPLETE;
        end
      end
      error_record_pkg::SEQ_COMPLETE:
      begin
        next_state = error_record_pkg::SEQ_IDLE;
      end
      default:
      begin
        next_state = error_record_pkg::SEQ_IDLE;
      end
    endcase
  end

endmodule

// File: logic/error_source_merge.sv
// Registered merge of the 1a and 1b self-check reports and the response error flags
`timescale 1ns/1ps

module error_source_merge (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          i_busy,
  input  logic                          i_self_check_en,
  input  logic                          i_err_1a,
  input  logic                          i_err_1b,
  input  error_record_pkg::error_record_t i_rec_1a,
  input  error_record_pkg::error_record_t i_rec_1b,
  input  logic                          i_slverr_wr,
  input  logic                          i_slverr_rd,
  input  logic                          i_poison_rd,
  output logic                          o_self_err,
  output logic                          o_resp_err,
  output error_record_pkg::error_record_t o_rec
);

  logic self_hit;
  logic resp_hit;

  // Self-check reports count only while the engine runs with checking on
  assign self_hit = i_busy & i_self_check_en & (i_err_1a | i_err_1b);

  // Any bus response error while busy
  assign resp_hit = i_busy & (i_slverr_wr | i_slverr_rd | i_poison_rd);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_self_err <= 1'b0;
      o_resp_err <= 1'b0;
    end
    else
    begin
      o_self_err <= self_hit;
      // A self-check error wins over a response error in the same cycle
      o_resp_err <= resp_hit & ~self_hit;
    end
  end

  // The record is taken with each counted error and held until the logs load
  always_ff @(posedge clk)
  begin
    if (self_hit | resp_hit)
    begin
      // 1a has priority when both algorithms report at once
      if (i_err_1a)
      begin
        o_rec <= i_rec_1a;
      end
      else
      begin
        o_rec <= i_rec_1b;
      end
    end
  end

endmodule

// File: logic/error_csr_pkg.sv
// Register word indices and packed layouts of the status and set words
`include "error_log_params.svh"

package error_csr_pkg;

  // Word index on the Wishbone address bus
  typedef enum logic [`WB_ADR_W-1:0] {
    CSR_OBSERVED = 3'd0,
    CSR_EXPECTED = 3'd1,
    CSR_STATUS   = 3'd2,
    CSR_SET      = 3'd3,
    CSR_ADDR_LO  = 3'd4,
    CSR_ADDR_HI  = 3'd5,
    CSR_RSVD_6   = 3'd6,
    CSR_RSVD_7   = 3'd7
  } csr_word_t;

  // Word 2, status in bit 0, loop number in 15:8, byte offset in 23:16
  typedef struct packed {
    logic [7:0]           rsvd_hi;
    logic [`OFFSET_W-1:0] offset;
    logic [`LOOP_W-1:0]   loop_num;
    logic [6:0]           rsvd_lo;
    logic                 error_status;
  } log_status_t;

  // Word 3, set number in 3:0, address increment in 15:8
  typedef struct packed {
    logic [15:0]        rsvd_hi;
    logic [`INCR_W-1:0] incr;
    logic [3:0]         rsvd_lo;
    logic [`SET_W-1:0]  set_num;
  } log_set_t;

endpackage

// File: logic/error_record_pkg.sv
// Captured error record type and sequencer state encoding
`include "error_log_params.svh"

package error_record_pkg;

  // One merged self-check report, taken from 1a or 1b
  typedef struct packed {
    logic [`PATTERN_W-1:0] observed;
    logic [`PATTERN_W-1:0] expected;
    logic [`LOOP_W-1:0]    loop_num;
    logic [`OFFSET_W-1:0]  offset;
    logic [`SET_W-1:0]     set_num;
    logic [`INCR_W-1:0]    incr;
    logic [`ADDR_W-1:0]    addr;
  } error_record_t;

  // Record loads every field, other only marks a response error
  typedef enum logic [2:0] {
    SEQ_IDLE     = 3'd0,
    SEQ_RECORD   = 3'd1,
    SEQ_OTHER    = 3'd2,
    SEQ_SEND     = 3'd3,
    SEQ_WAIT_ACK = 3'd4,
    SEQ_COMPLETE = 3'd5
  } seq_state_t;

endpackage

// File: logic/error_log_params.svh
// Field widths and register map constants for the error logger
`ifndef ERROR_LOG_PARAMS_SVH
`define ERROR_LOG_PARAMS_SVH

// Data pattern compared by the self-check engines
`define PATTERN_W 32

// Full failing address as seen by the test engine
`define ADDR_W 64

// Loop number, byte offset, set number and address increment
`define LOOP_W 8
`define OFFSET_W 8
`define SET_W 4
`define INCR_W 8

// Wishbone port, word addressed, eight words deep
`define WB_ADR_W 3
`define WB_DAT_W 32

// Bit of the status word that software writes low to acknowledge
`define STATUS_BIT 0

`endif
